// File: hw/rpi_bus_pkg.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// bus geometry defaults for the half-duplex host bus peripheral
// transfer phase enum shared by the address, write and read sequencers
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package rpi_bus_pkg;

	// width of one bus transfer
	parameter int BUS_WIDTH_DEFAULT = 8;

	// 4 transfers make a 32 bit data word
	parameter int TRANSACTIONS_PER_DATA_WORD_DEFAULT = 4;

	// 2 transfers make a 16 bit address word
	parameter int TRANSACTIONS_PER_ADDRESS_WORD_DEFAULT = 2;

	// bank select bits, taken from the top of the address word
	parameter int LOG2_OF_NUMBER_OF_BANKS_DEFAULT = 1;

	// low address bits that index a word inside one bank
	parameter int BANK_ADDRESS_WIDTH_DEFAULT = 4;

	// synchronizer depth, never below 2
	parameter int ANTI_META_DEFAULT = 3;

	parameter int ERROR_COUNT_WIDTH_DEFAULT = 8;

	// per-sequencer progress through one word
	typedef enum logic [1:0] {
		PHASE_IDLE     = 2'd0, // between parts
		PHASE_CAPTURED = 2'd1, // part taken during this enable pulse
		PHASE_COMPLETE = 2'd2  // all parts in, word awaiting finish
	} transfer_phase_t;

endpackage

// File: hw/bus_input_synchronizer.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// anti-metastability pipelines for enable, read, register_select and bus
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps

module bus_input_synchronizer #(
	parameter int BUS_WIDTH = rpi_bus_pkg::BUS_WIDTH_DEFAULT,
	parameter int ANTI_META = rpi_bus_pkg::ANTI_META_DEFAULT
) (
	input  logic                 clock,
	input  logic                 reset,
	input  logic [BUS_WIDTH-1:0] bus_in,
	input  logic                 read,
	input  logic                 register_select,
	input  logic                 enable,
	output logic [BUS_WIDTH-1:0] bus_synced,
	output logic                 enable_high,
	output logic                 enable_low,
	output logic                 read_high,
	output logic                 read_low,
	output logic                 select_data,
	output logic                 select_address
);

	logic [ANTI_META:0]   enable_pipeline;
	logic [ANTI_META:0]   read_pipeline;
	logic [ANTI_META:0]   select_pipeline;
	logic [BUS_WIDTH-1:0] bus_pipeline [ANTI_META:0];

	always_ff @(posedge clock) begin
		if (reset) begin
			enable_pipeline <= '0;
			read_pipeline   <= '0;
			select_pipeline <= '0;
		end else begin
			enable_pipeline <= {enable_pipeline[ANTI_META-1:0], enable};
			read_pipeline   <= {read_pipeline[ANTI_META-1:0], read};
			select_pipeline <= {select_pipeline[ANTI_META-1:0], register_select};
		end
	end

	// bus data rides alongside the controls so both line up at the oldest stage
	always_ff @(posedge clock) begin
		bus_pipeline[0] <= bus_in;
		for (int i = 1; i <= ANTI_META; i++) begin
			bus_pipeline[i] <= bus_pipeline[i-1];
		end
	end

	assign bus_synced = bus_pipeline[ANTI_META];

	// a level counts only once the two oldest stages agree
	assign enable_high    = enable_pipeline[ANTI_META:ANTI_META-1] == 2'b11;
	assign enable_low     = enable_pipeline[ANTI_META:ANTI_META-1] == 2'b00;
	assign read_high      = read_pipeline[ANTI_META:ANTI_META-1] == 2'b11;
	assign read_low       = read_pipeline[ANTI_META:ANTI_META-1] == 2'b00;
	assign select_data    = select_pipeline[ANTI_META:ANTI_META-1] == 2'b11;
	assign select_address = select_pipeline[ANTI_META:ANTI_META-1] == 2'b00;

endmodule

// File: hw/pollable_memory_bank.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// one bank of word memory, synchronous write and registered read
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps

module pollable_memory_bank #(
	parameter int DATA_WIDTH =
		rpi_bus_pkg::BUS_WIDTH_DEFAULT * rpi_bus_pkg::TRANSACTIONS_PER_DATA_WORD_DEFAULT,
	parameter int BANK_ADDRESS_WIDTH = rpi_bus_pkg::BANK_ADDRESS_WIDTH_DEFAULT
) (
	input  logic                          clock,
	input  logic                          reset,
	input  logic                          write_strobe,
	input  logic [BANK_ADDRESS_WIDTH-1:0] word_address,
	input  logic [DATA_WIDTH-1:0]         write_data_word,
	output logic [DATA_WIDTH-1:0]         read_data_word
);

	localparam int DEPTH = 2**BANK_ADDRESS_WIDTH;

	logic [DATA_WIDTH-1:0] memory [DEPTH];

	// untouched words read back as zero
	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 0; i < DEPTH; i++) begin
				memory[i] <= '0;
			end
		end else if (write_strobe) begin
			memory[word_address] <= write_data_word;
		end
	end

	// polled every cycle, one cycle of latency
	always_ff @(posedge clock) begin
		read_data_word <= memory[word_address];
	end

endmodule

// File: hw/half_duplex_rpi_bus.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// bus engine with address, write and read sequencers, word assembly,
// bank strobes, address auto-increment and interrupted-sequence counters
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps

module half_duplex_rpi_bus #(
	parameter int BUS_WIDTH                     = rpi_bus_pkg::BUS_WIDTH_DEFAULT,
	parameter int TRANSACTIONS_PER_DATA_WORD    = rpi_bus_pkg::TRANSACTIONS_PER_DATA_WORD_DEFAULT,
	parameter int TRANSACTIONS_PER_ADDRESS_WORD =
		rpi_bus_pkg::TRANSACTIONS_PER_ADDRESS_WORD_DEFAULT,
	parameter int LOG2_OF_NUMBER_OF_BANKS       = rpi_bus_pkg::LOG2_OF_NUMBER_OF_BANKS_DEFAULT,
	parameter int ERROR_COUNT_WIDTH             = rpi_bus_pkg::ERROR_COUNT_WIDTH_DEFAULT
) (
	input  logic                                              clock,
	input  logic                                              reset,
	input  logic [BUS_WIDTH-1:0]                              bus_synced,
	input  logic                                              enable_high,
	input  logic                                              enable_low,
	input  logic                                              read_high,
	input  logic                                              read_low,
	input  logic                                              select_data,
	input  logic                                              select_address,
	input  logic [BUS_WIDTH*TRANSACTIONS_PER_DATA_WORD-1:0]    read_data_word,
	output logic [BUS_WIDTH-1:0]                              bus_out,
	output logic                                              ack_valid,
	output logic [2**LOG2_OF_NUMBER_OF_BANKS-1:0]             write_strobe,
	output logic [2**LOG2_OF_NUMBER_OF_BANKS-1:0]             read_strobe,
	output logic [BUS_WIDTH*TRANSACTIONS_PER_DATA_WORD-1:0]    write_data_word,
	output logic [BUS_WIDTH*TRANSACTIONS_PER_ADDRESS_WORD-1:0] address_word,
	output logic [LOG2_OF_NUMBER_OF_BANKS-1:0]                bank,
	output logic [ERROR_COUNT_WIDTH-1:0]                      read_errors,
	output logic [ERROR_COUNT_WIDTH-1:0]                      write_errors,
	output logic [ERROR_COUNT_WIDTH-1:0]                      address_errors
);

	import rpi_bus_pkg::*;

	localparam int ADDRESS_WIDTH     = BUS_WIDTH * TRANSACTIONS_PER_ADDRESS_WORD;
	localparam int DATA_PART_BITS    =
		(TRANSACTIONS_PER_DATA_WORD > 1) ? $clog2(TRANSACTIONS_PER_DATA_WORD) : 1;
	localparam int ADDRESS_PART_BITS =
		(TRANSACTIONS_PER_ADDRESS_WORD > 1) ? $clog2(TRANSACTIONS_PER_ADDRESS_WORD) : 1;
	localparam logic [DATA_PART_BITS-1:0] DATA_TOP =
		DATA_PART_BITS'(TRANSACTIONS_PER_DATA_WORD - 1);
	localparam logic [ADDRESS_PART_BITS-1:0] ADDRESS_TOP =
		ADDRESS_PART_BITS'(TRANSACTIONS_PER_ADDRESS_WORD - 1);

	transfer_phase_t address_phase;
	transfer_phase_t write_phase;
	transfer_phase_t read_phase;

	logic [ADDRESS_PART_BITS-1:0] address_part; // counts down, msb part first
	logic [DATA_PART_BITS-1:0]    write_part;
	logic [DATA_PART_BITS-1:0]    read_part;

	logic [TRANSACTIONS_PER_ADDRESS_WORD-1:0][BUS_WIDTH-1:0] address_parts;
	logic [TRANSACTIONS_PER_DATA_WORD-1:0][BUS_WIDTH-1:0]    write_parts;
	logic [TRANSACTIONS_PER_DATA_WORD-1:0][BUS_WIDTH-1:0]    read_parts;

	logic read_word_pending;
	logic address_request, write_request, read_request;
	logic address_capture, write_capture, read_capture;
	logic address_active, write_active, read_active;
	logic address_busy, write_busy, read_busy;
	logic cancel_address, cancel_write, cancel_read;

	// direction and selector as decoded during an enable pulse
	assign read_request    = enable_high && read_high;
	assign write_request   = enable_high && read_low && select_data;
	assign address_request = enable_high && read_low && select_address;

	// one capture per enable pulse
	assign address_capture = address_request && address_phase == PHASE_IDLE;
	assign write_capture   = write_request && write_phase == PHASE_IDLE;
	assign read_capture    = read_request && read_phase == PHASE_IDLE;

	// a sequencer advances in enable_low cycles while not idle
	assign address_active = enable_low && address_phase != PHASE_IDLE;
	assign write_active   = enable_low && write_phase != PHASE_IDLE;
	assign read_active    = enable_low && read_phase != PHASE_IDLE;

	// mid-word means some part was taken but the word is not finished
	assign address_busy = address_phase != PHASE_IDLE || address_part != ADDRESS_TOP;
	assign write_busy   = write_phase != PHASE_IDLE || write_part != DATA_TOP;
	assign read_busy    = read_phase != PHASE_IDLE || read_part != DATA_TOP;

	assign cancel_address = (write_active || read_active) && address_busy;
	assign cancel_write   = (address_active || read_active) && write_busy;
	assign cancel_read    = (address_active || write_active) && read_busy;

	assign bank            = address_word[ADDRESS_WIDTH-1 -: LOG2_OF_NUMBER_OF_BANKS];
	assign write_data_word = write_parts;

	always_comb begin
		write_strobe = '0;
		read_strobe  = '0;
		if (write_phase == PHASE_COMPLETE) begin
			write_strobe[bank] = 1'b1;
		end
		if (read_phase == PHASE_COMPLETE) begin
			read_strobe[bank] = 1'b1;
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			ack_valid <= 1'b0;
		end else begin
			ack_valid <= read_request || write_request || address_request;
		end
	end

	always_ff @(posedge clock) begin
		if (address_capture) begin
			address_parts[address_part] <= bus_synced;
		end
		if (write_capture) begin
			write_parts[write_part] <= bus_synced;
		end
		if (enable_low && read_word_pending) begin
			read_parts <= read_data_word; // refreshed until the next pulse
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			address_phase  <= PHASE_IDLE;
			address_part   <= ADDRESS_TOP;
			address_errors <= '0;
		end else if (address_capture) begin
			address_phase <= PHASE_CAPTURED;
		end else if (enable_low) begin
			if (cancel_address) begin
				address_phase  <= PHASE_IDLE;
				address_part   <= ADDRESS_TOP;
				address_errors <= address_errors + 1'b1;
			end else if (address_phase == PHASE_CAPTURED) begin
				if (address_part == '0) begin
					address_phase <= PHASE_COMPLETE;
				end else begin
					address_phase <= PHASE_IDLE;
					address_part  <= address_part - 1'b1;
				end
			end else if (address_phase == PHASE_COMPLETE) begin
				address_phase <= PHASE_IDLE;
				address_part  <= ADDRESS_TOP;
			end
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			address_word <= '0;
		end else if (enable_low) begin
			if (address_phase == PHASE_COMPLETE && !cancel_address) begin
				address_word <= address_parts;
			end else if (write_phase == PHASE_COMPLETE || read_phase == PHASE_COMPLETE) begin
				address_word <= address_word + 1'b1; // auto-increment
			end
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			write_phase  <= PHASE_IDLE;
			write_part   <= DATA_TOP;
			write_errors <= '0;
		end else if (write_capture) begin
			write_phase <= PHASE_CAPTURED;
		end else if (enable_low) begin
			if (cancel_write) begin
				write_phase  <= PHASE_IDLE;
				write_part   <= DATA_TOP;
				write_errors <= write_errors + 1'b1;
			end else if (write_phase == PHASE_CAPTURED) begin
				if (write_part == '0) begin
					write_phase <= PHASE_COMPLETE; // strobes the bank next cycle
				end else begin
					write_phase <= PHASE_IDLE;
					write_part  <= write_part - 1'b1;
				end
			end else if (write_phase == PHASE_COMPLETE) begin
				write_phase <= PHASE_IDLE;
				write_part  <= DATA_TOP;
			end
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			read_phase  <= PHASE_IDLE;
			read_part   <= DATA_TOP;
			read_errors <= '0;
			bus_out     <= '0;
		end else if (read_capture) begin
			read_phase <= PHASE_CAPTURED;
			bus_out    <= read_parts[read_part]; // valid before ack_valid rises
		end else if (enable_low) begin
			if (cancel_read) begin
				read_phase  <= PHASE_IDLE;
				read_part   <= DATA_TOP;
				read_errors <= read_errors + 1'b1;
			end else if (read_phase == PHASE_CAPTURED) begin
				if (read_part == '0) begin
					read_phase <= PHASE_COMPLETE;
				end else begin
					read_phase <= PHASE_IDLE;
					read_part  <= read_part - 1'b1;
				end
			end else if (read_phase == PHASE_COMPLETE) begin
				read_phase <= PHASE_IDLE;
				read_part  <= DATA_TOP;
			end
		end
	end

	// a new word must be fetched after any completed sequence
	always_ff @(posedge clock) begin
		if (reset) begin
			read_word_pending <= 1'b1; // memory comes out of reset cleared
		end else if (enable_high) begin
			read_word_pending <= 1'b0;
		end else if (enable_low) begin
			if (address_phase == PHASE_COMPLETE || write_phase == PHASE_COMPLETE
					|| read_phase == PHASE_COMPLETE) begin
				read_word_pending <= 1'b1;
			end
		end
	end

endmodule

// File: hw/rpi_bus_subsystem.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// top level joining input synchronizer, bus engine and memory banks
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps

module rpi_bus_subsystem #(
	parameter int BUS_WIDTH                     = rpi_bus_pkg::BUS_WIDTH_DEFAULT,
	parameter int TRANSACTIONS_PER_DATA_WORD    = rpi_bus_pkg::TRANSACTIONS_PER_DATA_WORD_DEFAULT,
	parameter int TRANSACTIONS_PER_ADDRESS_WORD =
		rpi_bus_pkg::TRANSACTIONS_PER_ADDRESS_WORD_DEFAULT,
	parameter int LOG2_OF_NUMBER_OF_BANKS       = rpi_bus_pkg::LOG2_OF_NUMBER_OF_BANKS_DEFAULT,
	parameter int BANK_ADDRESS_WIDTH            = rpi_bus_pkg::BANK_ADDRESS_WIDTH_DEFAULT,
	parameter int ANTI_META                     = rpi_bus_pkg::ANTI_META_DEFAULT,
	parameter int ERROR_COUNT_WIDTH             = rpi_bus_pkg::ERROR_COUNT_WIDTH_DEFAULT
) (
	input  logic                         clock,
	input  logic                         reset,
	input  logic [BUS_WIDTH-1:0]         bus_in,
	input  logic                         read,
	input  logic                         register_select,
	input  logic                         enable,
	output logic [BUS_WIDTH-1:0]         bus_out,
	output logic                         bus_drive,
	output logic                         ack_valid,
	output logic [ERROR_COUNT_WIDTH-1:0] read_errors,
	output logic [ERROR_COUNT_WIDTH-1:0] write_errors,
	output logic [ERROR_COUNT_WIDTH-1:0] address_errors
);

	localparam int DATA_WIDTH      = BUS_WIDTH * TRANSACTIONS_PER_DATA_WORD;
	localparam int ADDRESS_WIDTH   = BUS_WIDTH * TRANSACTIONS_PER_ADDRESS_WORD;
	localparam int NUMBER_OF_BANKS = 2**LOG2_OF_NUMBER_OF_BANKS;

	logic [BUS_WIDTH-1:0]               bus_synced;
	logic                               enable_high, enable_low;
	logic                               read_high, read_low;
	logic                               select_data, select_address;
	logic [NUMBER_OF_BANKS-1:0]         write_strobe;
	logic [DATA_WIDTH-1:0]              write_data_word;
	logic [DATA_WIDTH-1:0]              read_data_word;
	logic [ADDRESS_WIDTH-1:0]           address_word;
	logic [LOG2_OF_NUMBER_OF_BANKS-1:0] bank;
	logic [DATA_WIDTH-1:0]              bank_words [NUMBER_OF_BANKS];

	assign bus_drive = read; // peripheral drives whenever the host reads

	bus_input_synchronizer #(
		.BUS_WIDTH(BUS_WIDTH),
		.ANTI_META(ANTI_META)
	) synchronizer (
		.clock(clock), .reset(reset), .bus_in(bus_in), .read(read),
		.register_select(register_select), .enable(enable), .bus_synced(bus_synced),
		.enable_high(enable_high), .enable_low(enable_low), .read_high(read_high),
		.read_low(read_low), .select_data(select_data), .select_address(select_address)
	);

	half_duplex_rpi_bus #(
		.BUS_WIDTH(BUS_WIDTH),
		.TRANSACTIONS_PER_DATA_WORD(TRANSACTIONS_PER_DATA_WORD),
		.TRANSACTIONS_PER_ADDRESS_WORD(TRANSACTIONS_PER_ADDRESS_WORD),
		.LOG2_OF_NUMBER_OF_BANKS(LOG2_OF_NUMBER_OF_BANKS),
		.ERROR_COUNT_WIDTH(ERROR_COUNT_WIDTH)
	) engine (
		.clock(clock), .reset(reset), .bus_synced(bus_synced),
		.enable_high(enable_high), .enable_low(enable_low), .read_high(read_high),
		.read_low(read_low), .select_data(select_data), .select_address(select_address),
		.read_data_word(read_data_word), .bus_out(bus_out), .ack_valid(ack_valid),
		.write_strobe(write_strobe), .read_strobe(), .write_data_word(write_data_word),
		.address_word(address_word), .bank(bank), .read_errors(read_errors),
		.write_errors(write_errors), .address_errors(address_errors)
	);

	for (genvar i = 0; i < NUMBER_OF_BANKS; i++) begin : banks
		pollable_memory_bank #(
			.DATA_WIDTH(DATA_WIDTH),
			.BANK_ADDRESS_WIDTH(BANK_ADDRESS_WIDTH)
		) memory_bank (
			.clock(clock), .reset(reset), .write_strobe(write_strobe[i]),
			.word_address(address_word[BANK_ADDRESS_WIDTH-1:0]),
			.write_data_word(write_data_word), .read_data_word(bank_words[i])
		);
	end

	// bits between the bank field and the word index are ignored
	assign read_data_word = bank_words[bank];

endmodule

// File: tests/rpi_bus_sva.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// assertions on bank strobes and ack_valid, bound into the bus engine
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps

module rpi_bus_sva #(
	parameter int LOG2_OF_NUMBER_OF_BANKS = rpi_bus_pkg::LOG2_OF_NUMBER_OF_BANKS_DEFAULT
) (
	input logic                                  clock,
	input logic                                  reset,
	input logic                                  enable_high,
	input logic                                  enable_low,
	input logic                                  ack_valid,
	input logic [2**LOG2_OF_NUMBER_OF_BANKS-1:0] write_strobe,
	input logic [2**LOG2_OF_NUMBER_OF_BANKS-1:0] read_strobe
);

	write_one_bank: assert property (@(posedge clock) disable iff (reset)
		$onehot0(write_strobe))
		else $error("write_strobe selects more than one bank");

	// a completed write strobes exactly once
	write_single_pulse: assert property (@(posedge clock) disable iff (reset)
		(write_strobe != '0) |=> (write_strobe == '0))
		else $error("write_strobe stayed high for two cycles");

	read_strobe_outside_pulse: assert property (@(posedge clock) disable iff (reset)
		!((read_strobe != '0) && enable_high))
		else $error("read_strobe high during an enable pulse");

	ack_only_with_enable: assert property (@(posedge clock) disable iff (reset)
		!(ack_valid && enable_low))
		else $error("ack_valid high while enable is low");

endmodule

bind half_duplex_rpi_bus rpi_bus_sva #(
	.LOG2_OF_NUMBER_OF_BANKS(LOG2_OF_NUMBER_OF_BANKS)
) engine_assertions (
	.clock(clock), .reset(reset), .enable_high(enable_high), .enable_low(enable_low),
	.ack_valid(ack_valid), .write_strobe(write_strobe), .read_strobe(read_strobe)
);

// File: tests/rpi_bus_tb.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// testbench with host bus tasks, stimulus table loop,
// reference memory model and value checks for the bus subsystem
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps

module rpi_bus_tb;

	import rpi_bus_pkg::*;

	localparam int BUS_WIDTH     = BUS_WIDTH_DEFAULT;
	localparam int DATA_PARTS    = TRANSACTIONS_PER_DATA_WORD_DEFAULT;
	localparam int ADDRESS_PARTS = TRANSACTIONS_PER_ADDRESS_WORD_DEFAULT;
	localparam int DATA_WIDTH    = BUS_WIDTH * DATA_PARTS;
	localparam int ADDRESS_WIDTH = BUS_WIDTH * ADDRESS_PARTS;
	localparam int COUNT_WIDTH   = ERROR_COUNT_WIDTH_DEFAULT;
	localparam int TIMEOUT       = 40; // cycles allowed for one ack_valid change

	typedef enum logic [2:0] {
		OP_WRITE_BLOCK, // set address, write count words
		OP_READ_BLOCK,  // set address, read count words back
		OP_CUT_ADDRESS, // set address, one address part, full write
		OP_CUT_WRITE,   // two write parts, full address
		OP_CUT_READ     // set address, two read parts, full write
	} operation_t;

	typedef struct packed {
		operation_t               operation;
		logic [ADDRESS_WIDTH-1:0] address;
		logic [DATA_WIDTH-1:0]    data; // zero picks random words
		logic [3:0]               count;
		logic [COUNT_WIDTH-1:0]   address_errors;
		logic [COUNT_WIDTH-1:0]   write_errors;
		logic [COUNT_WIDTH-1:0]   read_errors;
	} step_t;

	logic                     clock, reset, read, register_select, enable;
	logic [BUS_WIDTH-1:0]     bus_in, bus_out;
	logic                     bus_drive, ack_valid;
	logic [COUNT_WIDTH-1:0]   read_errors, write_errors, address_errors;
	step_t                    steps [$];
	logic [DATA_WIDTH-1:0]    reference_memory [int]; // keyed by bank and word index
	logic [ADDRESS_WIDTH-1:0] current_address;
	int                       seed;

	rpi_bus_subsystem #(
		.BUS_WIDTH(BUS_WIDTH), .TRANSACTIONS_PER_DATA_WORD(DATA_PARTS),
		.TRANSACTIONS_PER_ADDRESS_WORD(ADDRESS_PARTS),
		.LOG2_OF_NUMBER_OF_BANKS(LOG2_OF_NUMBER_OF_BANKS_DEFAULT),
		.BANK_ADDRESS_WIDTH(BANK_ADDRESS_WIDTH_DEFAULT),
		.ANTI_META(ANTI_META_DEFAULT), .ERROR_COUNT_WIDTH(COUNT_WIDTH)
	) UUT (
		.clock(clock), .reset(reset), .bus_in(bus_in), .read(read),
		.register_select(register_select), .enable(enable), .bus_out(bus_out),
		.bus_drive(bus_drive), .ack_valid(ack_valid), .read_errors(read_errors),
		.write_errors(write_errors), .address_errors(address_errors)
	);

	always #5 clock = ~clock;

	task automatic abort_run(input string reason);
		$display("%s", reason);
		$display("tests failed");
		$fatal(1, "simulation stopped at the first failure");
	endtask

	task automatic check_value(input string name, input logic [DATA_WIDTH-1:0] actual,
			input logic [DATA_WIDTH-1:0] expected);
		if (actual !== expected) begin
			abort_run($sformatf("CHECK FAILED %s got 0x%h expected 0x%h",
				name, actual, expected));
		end
	endtask

	task automatic wait_for_ack(input logic level);
		int cycles;
		cycles = 0;
		while (ack_valid !== level) begin
			@(posedge clock);
			#1;
			cycles++;
			if (cycles > TIMEOUT) begin
				abort_run($sformatf("ack_valid never went to %0d after an enable change", level));
			end
		end
	endtask

	// one enable pulse, entered 1 ns after a rising edge
	task automatic bus_transfer(input logic is_read, input logic is_data,
			input logic [BUS_WIDTH-1:0] value, output logic [BUS_WIDTH-1:0] sampled);
		read            = is_read;
		register_select = is_data;
		bus_in          = value;
		enable          = 1'b1;
		wait_for_ack(1'b1);
		sampled = bus_out;
		check_value("bus_drive", DATA_WIDTH'(bus_drive), DATA_WIDTH'(is_read));
		enable = 1'b0;
		wait_for_ack(1'b0);
		repeat (ANTI_META_DEFAULT + 2) @(posedge clock); // idle gap before next pulse
		#1;
	endtask

	// bank bits over the word index, middle bits ignored
	function automatic int model_key(input logic [ADDRESS_WIDTH-1:0] address);
		return int'({address[ADDRESS_WIDTH-1 -: LOG2_OF_NUMBER_OF_BANKS_DEFAULT],
			address[BANK_ADDRESS_WIDTH_DEFAULT-1:0]});
	endfunction

	task automatic set_address(input logic [ADDRESS_WIDTH-1:0] address, input int parts);
		logic [BUS_WIDTH-1:0] ignored;
		for (int i = ADDRESS_PARTS - 1; i >= ADDRESS_PARTS - parts; i--) begin
			bus_transfer(1'b0, 1'b0, address[i*BUS_WIDTH +: BUS_WIDTH], ignored);
		end
		if (parts == ADDRESS_PARTS) begin
			current_address = address;
		end
	endtask

	task automatic write_word(input logic [DATA_WIDTH-1:0] data, input int parts);
		logic [BUS_WIDTH-1:0] ignored;
		for (int i = DATA_PARTS - 1; i >= DATA_PARTS - parts; i--) begin
			bus_transfer(1'b0, 1'b1, data[i*BUS_WIDTH +: BUS_WIDTH], ignored);
		end
		if (parts == DATA_PARTS) begin
			reference_memory[model_key(current_address)] = data;
			current_address = current_address + ADDRESS_WIDTH'(1); // auto-increment
		end
	endtask

	task automatic read_word(input int parts);
		logic [BUS_WIDTH-1:0]  part;
		logic [DATA_WIDTH-1:0] word;
		logic [DATA_WIDTH-1:0] expected;
		int                    key;
		word = '0;
		for (int i = 0; i < parts; i++) begin
			bus_transfer(1'b1, 1'b0, '0, part);
			word = {word[DATA_WIDTH-BUS_WIDTH-1:0], part}; // msb part arrives first
		end
		if (parts == DATA_PARTS) begin
			key      = model_key(current_address);
			expected = reference_memory.exists(key) ? reference_memory[key] : '0;
			check_value($sformatf("bus_out word at 0x%h", current_address), word, expected);
			current_address = current_address + ADDRESS_WIDTH'(1);
		end
	endtask

	task automatic apply_step(input step_t step);
		logic [DATA_WIDTH-1:0] word;
		case (step.operation)
			OP_WRITE_BLOCK: begin
				set_address(step.address, ADDRESS_PARTS);
				for (int i = 0; i < int'(step.count); i++) begin
					word = (step.data != '0) ? step.data + DATA_WIDTH'(i)
						: DATA_WIDTH'($random(seed));
					write_word(word, DATA_PARTS);
				end
			end
			OP_READ_BLOCK: begin
				set_address(step.address, ADDRESS_PARTS);
				for (int i = 0; i < int'(step.count); i++) begin
					read_word(DATA_PARTS);
				end
			end
			OP_CUT_ADDRESS: begin
				set_address(step.address, ADDRESS_PARTS);
				set_address(~step.address, 1); // upper part only
				write_word(DATA_WIDTH'($random(seed)), DATA_PARTS);
			end
			OP_CUT_WRITE: begin
				write_word(DATA_WIDTH'($random(seed)), 2);
				set_address(step.address, ADDRESS_PARTS);
			end
			OP_CUT_READ: begin
				set_address(step.address, ADDRESS_PARTS);
				read_word(2);
				write_word(DATA_WIDTH'($random(seed)), DATA_PARTS);
			end
			default: abort_run("stimulus table holds an unknown operation");
		endcase
		check_value("address_errors", DATA_WIDTH'(address_errors),
			DATA_WIDTH'(step.address_errors));
		check_value("write_errors", DATA_WIDTH'(write_errors), DATA_WIDTH'(step.write_errors));
		check_value("read_errors", DATA_WIDTH'(read_errors), DATA_WIDTH'(step.read_errors));
	endtask

	initial begin
		clock           = 1'b0;
		reset           = 1'b1;
		read            = 1'b0;
		register_select = 1'b0;
		enable          = 1'b0;
		bus_in          = '0;
		current_address = '0;
		seed            = 96;
		// operation, address, data, count, expected address, write and read errors
		steps.push_back(step_t'{OP_READ_BLOCK,  16'h0000, 32'h0, 4'd1, 8'd0, 8'd0, 8'd0});
		steps.push_back(step_t'{OP_WRITE_BLOCK, 16'h0003, 32'h0, 4'd1, 8'd0, 8'd0, 8'd0});
		steps.push_back(step_t'{OP_READ_BLOCK,  16'h0003, 32'h0, 4'd1, 8'd0, 8'd0, 8'd0});
		steps.push_back(step_t'{OP_WRITE_BLOCK, 16'h0008, 32'h0, 4'd3, 8'd0, 8'd0, 8'd0});
		steps.push_back(step_t'{OP_WRITE_BLOCK, 16'h8008, 32'hB1B1_0000, 4'd3,
			8'd0, 8'd0, 8'd0});
		steps.push_back(step_t'{OP_READ_BLOCK,  16'h0008, 32'h0, 4'd3, 8'd0, 8'd0, 8'd0});
		steps.push_back(step_t'{OP_READ_BLOCK,  16'h8008, 32'h0, 4'd3, 8'd0, 8'd0, 8'd0});
		steps.push_back(step_t'{OP_CUT_ADDRESS, 16'h0005, 32'h0, 4'd0, 8'd1, 8'd0, 8'd0});
		steps.push_back(step_t'{OP_READ_BLOCK,  16'h0005, 32'h0, 4'd1, 8'd1, 8'd0, 8'd0});
		steps.push_back(step_t'{OP_CUT_WRITE,   16'h000A, 32'h0, 4'd0, 8'd1, 8'd1, 8'd0});
		steps.push_back(step_t'{OP_WRITE_BLOCK, 16'h000A, 32'h0, 4'd1, 8'd1, 8'd1, 8'd0});
		steps.push_back(step_t'{OP_READ_BLOCK,  16'h000A, 32'h0, 4'd1, 8'd1, 8'd1, 8'd0});
		steps.push_back(step_t'{OP_CUT_READ,    16'h000C, 32'h0, 4'd0, 8'd1, 8'd1, 8'd1});
		steps.push_back(step_t'{OP_READ_BLOCK,  16'h000C, 32'h0, 4'd1, 8'd1, 8'd1, 8'd1});
		repeat (5) @(posedge clock);
		#1;
		reset = 1'b0;
		check_value("ack_valid", DATA_WIDTH'(ack_valid), '0);
		foreach (steps[i]) begin
			apply_step(steps[i]);
		end
		$display("all tests passed");
		$finish;
	end

endmodule

// File: compile.f
hw/rpi_bus_pkg.sv
hw/bus_input_synchronizer.sv
hw/pollable_memory_bank.sv
hw/half_duplex_rpi_bus.sv
hw/rpi_bus_subsystem.sv
tests/rpi_bus_sva.sv
tests/rpi_bus_tb.sv

// File: run.sh
#!/usr/bin/env bash
# builds the testbench with Verilator and runs it
# a failing run ends in $fatal, which gives a nonzero exit status
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
	--top-module rpi_bus_tb \
	-Mdir obj_dir \
	-f compile.f

./obj_dir/Vrpi_bus_tb
